//--- logic/calc_pkg.sv
package calc_pkg;

    // datapath and key widths
    localparam int data_w   = 8;
    localparam int addr_w   = 5;
    localparam int num_regs = 32;
    localparam int key_w    = 4;

    typedef logic [data_w-1:0] data_t;
    typedef logic [addr_w-1:0] addr_t;

    // key classes
    localparam logic [key_w-1:0] key_enter = 4'd15;
    localparam logic [key_w-1:0] digit_max = 4'd9;

    // operand slot rotation through registers 1 to 30
    localparam addr_t slot_first = 5'd1;
    localparam addr_t slot_last  = 5'd28;
    localparam addr_t slot_step  = 5'd3;

    typedef enum logic [key_w-1:0] {
        op_add = 4'd10,
        op_sub = 4'd11,
        op_and = 4'd12,
        op_or  = 4'd13,
        op_mul = 4'd14
    } alu_op_e;

    // a key is a digit nibble or an operation, depending on the step
    typedef union packed {
        logic [key_w-1:0] digit;
        alu_op_e          op;
    } key_word_u;

    // key sequencer state codes
    localparam logic [3:0] seq_wait_d1  = 4'd0;
    localparam logic [3:0] seq_chk_d1   = 4'd1;
    localparam logic [3:0] seq_wait_op  = 4'd2;
    localparam logic [3:0] seq_chk_op   = 4'd3;
    localparam logic [3:0] seq_wait_d2  = 4'd4;
    localparam logic [3:0] seq_chk_d2   = 4'd5;
    localparam logic [3:0] seq_wait_ent = 4'd6;
    localparam logic [3:0] seq_chk_ent  = 4'd7;
    localparam logic [3:0] seq_launch   = 4'd8;
    localparam logic [3:0] seq_req      = 4'd9;

endpackage

//--- logic/calc_ifs.sv
`timescale 1ns/100ps

// calculation request from sequencer to engine
interface calc_req_if import calc_pkg::*; ();

    logic    valid;
    logic    ready;
    alu_op_e op;
    addr_t   base;

    modport requester (
        output valid,
        output op,
        output base,
        input  ready
    );

    modport executor (
        input  valid,
        input  op,
        input  base,
        output ready
    );

endinterface

// two asynchronous read ports of the register file
interface regfile_rd_if import calc_pkg::*; ();

    addr_t addr_a;
    addr_t addr_b;
    data_t data_a;
    data_t data_b;

    modport reader (
        output addr_a,
        output addr_b,
        input  data_a,
        input  data_b
    );

    modport store (
        input  addr_a,
        input  addr_b,
        output data_a,
        output data_b
    );

endinterface

//--- logic/key_sequencer.sv
`timescale 1ns/100ps

module key_sequencer import calc_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  key_word_u  key_code_i,
    input  logic       key_detect_i,
    output logic       key_error_o,
    output logic       opd_we_o,
    output addr_t      opd_addr_o,
    output data_t      opd_data_o,
    calc_req_if.requester req
);

    logic [3:0] state;
    key_word_u  key_q;
    alu_op_e    op_q;
    addr_t      base_q;
    logic       waiting;
    logic       xfer;

    // keys are only taken in the waiting steps
    assign waiting = (state == seq_wait_d1) || (state == seq_wait_op) ||
                     (state == seq_wait_d2) || (state == seq_wait_ent);

    assign xfer = req.valid && req.ready;

    assign req.valid = (state == seq_req);
    assign req.op    = op_q;
    assign req.base  = base_q;

    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i) begin
            state       <= seq_wait_d1;
            base_q      <= slot_first;
            key_error_o <= 1'b0;
            opd_we_o    <= 1'b0;
        end else begin
            key_error_o <= 1'b0;
            opd_we_o    <= 1'b0;
            case (state)
                seq_wait_d1: begin
                    if (key_detect_i) begin
                        state <= seq_chk_d1;
                    end
                end
                seq_chk_d1: begin
                    if (key_q.digit <= digit_max) begin
                        opd_we_o <= 1'b1;
                        state    <= seq_wait_op;
                    end else begin
                        key_error_o <= 1'b1;
                        state       <= seq_wait_d1;
                    end
                end
                seq_wait_op: begin
                    if (key_detect_i) begin
                        state <= seq_chk_op;
                    end
                end
                seq_chk_op: begin
                    if (key_q.digit > digit_max && key_q.digit != key_enter) begin
                        state <= seq_wait_d2;
                    end else begin
                        key_error_o <= 1'b1;
                        state       <= seq_wait_op;
                    end
                end
                seq_wait_d2: begin
                    if (key_detect_i) begin
                        state <= seq_chk_d2;
                    end
                end
                seq_chk_d2: begin
                    if (key_q.digit <= digit_max) begin
                        opd_we_o <= 1'b1;
                        state    <= seq_wait_ent;
                    end else begin
                        key_error_o <= 1'b1;
                        state       <= seq_wait_d2;
                    end
                end
                seq_wait_ent: begin
                    if (key_detect_i) begin
                        state <= seq_chk_ent;
                    end
                end
                seq_chk_ent: begin
                    if (key_q.digit == key_enter) begin
                        state <= seq_launch;
                    end else begin
                        key_error_o <= 1'b1;
                        state       <= seq_wait_ent;
                    end
                end
                seq_launch: begin
                    state <= seq_req;
                end
                seq_req: begin
                    // hold the request until the engine takes it
                    if (xfer) begin
                        if (base_q == slot_last) begin
                            base_q <= slot_first;
                        end else begin
                            base_q <= base_q + slot_step;
                        end
                        state <= seq_wait_d1;
                    end
                end
                default: begin
                    state <= seq_wait_d1;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (key_detect_i && waiting) begin
            key_q <= key_code_i;
        end
        if (state == seq_chk_d1) begin
            opd_addr_o <= base_q;
            opd_data_o <= {{(data_w-key_w){1'b0}}, key_q.digit};
        end else if (state == seq_chk_d2) begin
            opd_addr_o <= base_q + addr_t'(1);
            opd_data_o <= {{(data_w-key_w){1'b0}}, key_q.digit};
        end
        if (state == seq_chk_op) begin
            op_q <= key_q.op;
        end
    end

endmodule

//--- logic/operand_regfile.sv
`timescale 1ns/100ps

module operand_regfile import calc_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  opd_we_i,
    input  addr_t opd_addr_i,
    input  data_t opd_data_i,
    input  logic  res_we_i,
    input  addr_t res_addr_i,
    input  data_t res_data_i,
    regfile_rd_if.store rd
);

    data_t regs [num_regs];

    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // result write has priority
            if (res_we_i) begin
                regs[res_addr_i] <= res_data_i;
            end else if (opd_we_i) begin
                regs[opd_addr_i] <= opd_data_i;
            end
        end
    end

    assign rd.data_a = regs[rd.addr_a];
    assign rd.data_b = regs[rd.addr_b];

endmodule

//--- logic/alu_engine.sv
`timescale 1ns/100ps

module alu_engine import calc_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    calc_req_if.executor  req,
    regfile_rd_if.reader  rd,
    output logic  res_we_o,
    output addr_t res_addr_o,
    output data_t res_data_o,
    output data_t result_o,
    output logic  result_valid_o,
    output addr_t result_addr_o
);

    alu_op_e op_q;
    addr_t   base_q;
    data_t   res_q;
    data_t   alu_out;
    logic    rd_pend;
    logic    wr_pend;
    logic    xfer;

    assign req.ready = !rd_pend && !wr_pend;
    assign xfer      = req.valid && req.ready;

    // operands sit at base and base+1
    assign rd.addr_a = base_q;
    assign rd.addr_b = base_q + addr_t'(1);

    always_comb begin
        case (op_q)
            op_add:  alu_out = rd.data_a + rd.data_b;
            op_sub:  alu_out = rd.data_a - rd.data_b;
            op_and:  alu_out = rd.data_a & rd.data_b;
            op_or:   alu_out = rd.data_a | rd.data_b;
            op_mul:  alu_out = rd.data_a * rd.data_b;
            default: alu_out = '0;
        endcase
    end

    assign res_we_o   = wr_pend;
    assign res_addr_o = base_q + addr_t'(2);
    assign res_data_o = res_q;

    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i) begin
            rd_pend        <= 1'b0;
            wr_pend        <= 1'b0;
            result_valid_o <= 1'b0;
            result_o       <= '0;
            result_addr_o  <= '0;
        end else begin
            rd_pend        <= xfer;
            wr_pend        <= rd_pend;
            result_valid_o <= wr_pend;
            if (wr_pend) begin
                result_o      <= res_q;
                result_addr_o <= res_addr_o;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer) begin
            op_q   <= req.op;
            base_q <= req.base;
        end
        // result is taken the cycle after the request
        if (rd_pend) begin
            res_q <= alu_out;
        end
    end

endmodule

//--- logic/keypad_calc_top.sv
`timescale 1ns/100ps

module keypad_calc_top import calc_pkg::*; (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic [key_w-1:0]  key_code_i,
    input  logic              key_detect_i,
    output logic              key_error_o,
    output logic [data_w-1:0] result_o,
    output logic              result_valid_o,
    output logic [addr_w-1:0] result_addr_o
);

    logic  opd_we;
    addr_t opd_addr;
    data_t opd_data;
    logic  res_we;
    addr_t res_addr;
    data_t res_data;

    calc_req_if   req_if ();
    regfile_rd_if rd_if ();

    key_sequencer u_key_sequencer (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .key_code_i   (key_code_i),
        .key_detect_i (key_detect_i),
        .key_error_o  (key_error_o),
        .opd_we_o     (opd_we),
        .opd_addr_o   (opd_addr),
        .opd_data_o   (opd_data),
        .req          (req_if.requester)
    );

    operand_regfile u_operand_regfile (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .opd_we_i   (opd_we),
        .opd_addr_i (opd_addr),
        .opd_data_i (opd_data),
        .res_we_i   (res_we),
        .res_addr_i (res_addr),
        .res_data_i (res_data),
        .rd         (rd_if.store)
    );

    alu_engine u_alu_engine (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .req            (req_if.executor),
        .rd             (rd_if.reader),
        .res_we_o       (res_we),
        .res_addr_o     (res_addr),
        .res_data_o     (res_data),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .result_addr_o  (result_addr_o)
    );

endmodule

//--- tb/tb_keypad_calc.sv
`timescale 1ns/100ps

module tb_keypad_calc import calc_pkg::*; ();

    logic       clk_i = 1'b0;
    logic       reset_i;
    logic [3:0] key_code_i;
    logic       key_detect_i;
    logic       key_error_o;
    logic [7:0] result_o;
    logic       result_valid_o;
    logic [4:0] result_addr_o;

    int    errors = 0;
    int    checks = 0;
    int    tests = 0;
    int    valid_run_errs = 0;
    int    overlap_errs = 0;
    addr_t exp_base = slot_first;

    keypad_calc_top DUT (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .key_code_i     (key_code_i),
        .key_detect_i   (key_detect_i),
        .key_error_o    (key_error_o),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .result_addr_o  (result_addr_o)
    );

    always #20 clk_i = ~clk_i;

    // result pulse lasts one cycle only
    one_cycle_result: assert property (@(posedge clk_i) disable iff (reset_i)
        result_valid_o |=> !result_valid_o)
        else begin
            $display("Error: result_valid_o expected %h got %h", 1'b0, 1'b1);
            valid_run_errs++;
        end

    no_error_with_result: assert property (@(posedge clk_i) disable iff (reset_i)
        !(key_error_o && result_valid_o))
        else begin
            $display("key_error_o and result_valid_o were high in the same cycle");
            overlap_errs++;
        end

    function automatic int total_errors();
        return errors + valid_run_errs + overlap_errs;
    endfunction

    // expected result, modulo 256
    function automatic data_t ref_result(input logic [3:0] op, input logic [3:0] a,
                                         input logic [3:0] b);
        int x;
        int y;
        int r;
        x = int'(a);
        y = int'(b);
        case (op)
            op_add:  r = x + y;
            op_sub:  r = x - y;
            op_and:  r = x & y;
            op_or:   r = x | y;
            op_mul:  r = x * y;
            default: r = 0;
        endcase
        return data_t'(r);
    endfunction

    function automatic logic [3:0] rand_digit();
        return 4'($urandom_range(9, 0));
    endfunction

    function automatic logic [3:0] rand_op();
        return 4'(32'd10 + $urandom_range(4, 0));
    endfunction

    function automatic void report_test(input string name, input int errs_before);
        tests++;
        if (total_errors() == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d error(s)", name, total_errors() - errs_before);
        end
    endfunction

    task automatic apply_reset();
        @(posedge clk_i);
        reset_i <= 1'b1;
        repeat (3) @(posedge clk_i);
        reset_i  <= 1'b0;
        exp_base = slot_first;
    endtask

    // one detect pulse, then watch a few cycles for the key verdict
    task automatic press_key(input logic [3:0] code, input logic bad);
        int   n;
        logic err_seen;
        logic res_seen;
        err_seen = 1'b0;
        res_seen = 1'b0;
        @(posedge clk_i);
        key_code_i   <= code;
        key_detect_i <= 1'b1;
        @(posedge clk_i);
        key_detect_i <= 1'b0;
        for (n = 0; n < 4; n++) begin
            @(negedge clk_i);
            err_seen = err_seen | key_error_o;
            res_seen = res_seen | result_valid_o;
        end
        checks += 2;
        assert (err_seen == bad) else begin
            $display("Error: key_error_o for key %h expected %h got %h", code, bad, err_seen);
            errors++;
        end
        assert (!res_seen) else begin
            $display("Error: result_valid_o for key %h expected %h got %h",
                     code, 1'b0, res_seen);
            errors++;
        end
    endtask

    task automatic finish_calc(input logic [3:0] a, input logic [3:0] op,
                               input logic [3:0] b);
        int    n;
        logic  seen;
        data_t exp_val;
        addr_t exp_addr;
        exp_val  = ref_result(op, a, b);
        exp_addr = exp_base + addr_t'(2);
        seen = 1'b0;
        for (n = 0; n < 20 && !seen; n++) begin
            @(negedge clk_i);
            seen = result_valid_o;
        end
        checks++;
        assert (seen) else begin
            $display("no result for %h op %h %h within 20 cycles", a, op, b);
            errors++;
        end
        if (seen) begin
            checks += 2;
            assert (result_o == exp_val) else begin
                $display("Error: result_o expected %h got %h", exp_val, result_o);
                errors++;
            end
            assert (result_addr_o == exp_addr) else begin
                $display("Error: result_addr_o expected %h got %h", exp_addr, result_addr_o);
                errors++;
            end
        end
        if (exp_base == slot_last) begin
            exp_base = slot_first;
        end else begin
            exp_base = exp_base + slot_step;
        end
    endtask

    task automatic run_calc(input logic [3:0] a, input logic [3:0] op, input logic [3:0] b);
        press_key(a, 1'b0);
        press_key(op, 1'b0);
        press_key(b, 1'b0);
        press_key(key_enter, 1'b0);
        finish_calc(a, op, b);
    endtask

    initial begin
        logic [3:0] a;
        logic [3:0] b;
        logic [3:0] op;
        int         start;
        reset_i      = 1'b1;
        key_code_i   = 4'd0;
        key_detect_i = 1'b0;
        void'($urandom(54));

        start = total_errors();
        apply_reset();
        @(negedge clk_i);
        checks += 4;
        assert (key_error_o == 1'b0) else begin
            $display("Error: key_error_o expected %h got %h", 1'b0, key_error_o);
            errors++;
        end
        assert (result_valid_o == 1'b0) else begin
            $display("Error: result_valid_o expected %h got %h", 1'b0, result_valid_o);
            errors++;
        end
        assert (result_o == 8'h00) else begin
            $display("Error: result_o expected %h got %h", 8'h00, result_o);
            errors++;
        end
        assert (result_addr_o == 5'h00) else begin
            $display("Error: result_addr_o expected %h got %h", 5'h00, result_addr_o);
            errors++;
        end
        report_test("reset", start);

        start = total_errors();
        for (int i = 10; i <= 14; i++) begin
            run_calc(rand_digit(), 4'(i), rand_digit());
        end
        report_test("arithmetic", start);

        // digit steps reject operation and enter codes
        start = total_errors();
        a  = rand_digit();
        b  = rand_digit();
        op = rand_op();
        press_key(rand_op(), 1'b1);
        press_key(key_enter, 1'b1);
        press_key(a, 1'b0);
        press_key(op, 1'b0);
        press_key(rand_op(), 1'b1);
        press_key(b, 1'b0);
        press_key(key_enter, 1'b0);
        finish_calc(a, op, b);
        report_test("invalid digit", start);

        start = total_errors();
        a  = rand_digit();
        b  = rand_digit();
        op = rand_op();
        press_key(a, 1'b0);
        press_key(rand_digit(), 1'b1);
        press_key(key_enter, 1'b1);
        press_key(op, 1'b0);
        press_key(b, 1'b0);
        press_key(rand_digit(), 1'b1);
        press_key(rand_op(), 1'b1);
        press_key(key_enter, 1'b0);
        finish_calc(a, op, b);
        report_test("invalid operation", start);

        // bases 1 to 28, then back to 1
        start = total_errors();
        apply_reset();
        for (int i = 0; i < 11; i++) begin
            run_calc(rand_digit(), rand_op(), rand_digit());
        end
        report_test("slot rotation", start);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, total_errors());
        if (total_errors() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
logic/calc_pkg.sv
logic/calc_ifs.sv
logic/key_sequencer.sv
logic/operand_regfile.sv
logic/alu_engine.sv
logic/keypad_calc_top.sv
tb/tb_keypad_calc.sv

//--- run_sim.sh
#!/bin/sh
# build and run the keypad calculator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps \
    --top-module tb_keypad_calc -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_keypad_calc)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
